// File: hdl/mam_pkg.sv
// Package: flit width, command word union, response header constants, memory word helpers
package mam_pkg;

   localparam int flit_width = 16;
   localparam int beats_width = 13;
   localparam int header_flits = 2;   // Destination flit, then type and id flit

   // Response packet header
   localparam logic [flit_width-1:0] hdr_dest_flit = '0;
   localparam logic [5:0] hdr_type_bits = 6'b011111;
   localparam int hdr_id_bits = flit_width - $bits(hdr_type_bits);

   localparam int max_word_width = 512;   // Widest memory word the swap helper handles

   // Command word as seen for a burst access
   typedef struct packed {
      logic write;
      logic burst;
      logic sync;
      logic [beats_width-1:0] beats;
   } cmd_burst_t;

   // Command word as seen for a single access
   typedef struct packed {
      logic write;
      logic burst;
      logic sync;
      logic [beats_width-1:0] strb;   // Byte strobe in the low bits
   } cmd_single_t;

   // The burst flag picks the view
   typedef union packed {
      cmd_burst_t burst_view;
      cmd_single_t single_view;
   } mam_cmd_t;

   // Number of flits in a word of the given width
   function automatic int flits_of(input int width);
      return width / flit_width;
   endfunction

   // Counter width for values 0 .. n-1, at least one bit
   function automatic int cnt_bits(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

   // Reverse the order of the low nbytes bytes
   function automatic logic [max_word_width-1:0] swap_bytes(
      input logic [max_word_width-1:0] word,
      input int nbytes
   );
      logic [max_word_width-1:0] res;
      res = '0;
      for (int i = 0; i < max_word_width / 8; i++) begin
         if (i < nbytes) begin
            res[i*8 +: 8] = word[(nbytes-1-i)*8 +: 8];
         end
      end
      return res;
   endfunction

endpackage

// File: hdl/mam_cmd_parser.sv
// Command parser: inbound flit decoding, memory request issue, write word assembly, sync wait
module mam_cmd_parser #(
   parameter int data_width = 32,
   parameter int addr_width = 32,
   parameter bit big_endian = 1
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mam_pkg::flit_width-1:0]  in_data,
   input  logic                            in_last,
   input  logic                            in_valid,
   output logic                            in_ready,
   output logic                            req_valid,
   input  logic                            req_ready,
   output logic                            req_rw,
   output logic [addr_width-1:0]           req_addr,
   output logic                            req_burst,
   output logic [mam_pkg::beats_width-1:0] req_beats,
   output logic                            req_sync,
   output logic                            write_valid,
   output logic [data_width-1:0]           write_data,
   output logic [data_width/8-1:0]         write_strb,
   input  logic                            write_ready,
   input  logic                            write_complete,
   input  logic                            busy,
   output logic                            read_start,
   output logic [mam_pkg::beats_width-1:0] read_beats,
   output logic                            sync_ack
);
   import mam_pkg::*;

   localparam int addr_flits = flits_of(addr_width);
   localparam int word_flits = flits_of(data_width);
   localparam int cnt_max = (addr_flits > word_flits) ? addr_flits : word_flits;
   localparam int cnt_width = cnt_bits(cnt_max);

   typedef enum logic [3:0] {
      st_hdr0,       // First header flit of a command packet
      st_hdr1,
      st_cmd,
      st_addr,
      st_req,
      st_wr_hdr,     // Header of a packet that continues burst data
      st_burst,
      st_single,
      st_write,
      st_sync_wait
   } state_t;

   state_t state;
   logic [cnt_width-1:0] flit_cnt;     // Address flit or word flit index
   logic hdr_idx;                      // Header flit index inside write data
   logic [beats_width-1:0] beats_left;
   logic need_hdr;                     // Previous flit closed its packet
   logic [data_width-1:0] word_buf;
   mam_cmd_t cmd;
   logic flit_acc;
   logic word_done;

   assign cmd = mam_cmd_t'(in_data);
   assign flit_acc = in_valid && in_ready;
   assign word_done = flit_cnt == cnt_width'(word_flits - 1);

   always_comb begin
      case (state)
         st_hdr0: in_ready = !busy;   // Hold off while a response is going out
         st_req, st_write, st_sync_wait: in_ready = 1'b0;
         default: in_ready = 1'b1;
      endcase
   end

   assign req_valid = state == st_req;
   assign write_valid = state == st_write;
   assign read_start = req_valid && req_ready && !req_rw;
   assign read_beats = req_beats;
   assign sync_ack = (state == st_sync_wait) && write_complete;

   assign write_data = big_endian ? word_buf
                     : data_width'(swap_bytes(max_word_width'(word_buf), data_width / 8));

   // Control path
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_hdr0;
         flit_cnt <= '0;
         hdr_idx <= 1'b0;
         beats_left <= '0;
         need_hdr <= 1'b0;
      end else begin
         case (state)
            st_hdr0: if (flit_acc) state <= st_hdr1;
            st_hdr1: if (flit_acc) state <= st_cmd;
            st_cmd: begin
               if (flit_acc) begin
                  flit_cnt <= '0;
                  state <= st_addr;
               end
            end
            st_addr: begin
               if (flit_acc) begin
                  flit_cnt <= flit_cnt + 1'b1;
                  if (flit_cnt == cnt_width'(addr_flits - 1)) begin
                     need_hdr <= in_last;   // Burst data may start in a new packet
                     state <= st_req;
                  end
               end
            end
            st_req: begin
               if (req_ready) begin
                  flit_cnt <= '0;
                  hdr_idx <= 1'b0;
                  beats_left <= req_beats;
                  if (!req_rw)
                     state <= st_hdr0;
                  else if (!req_burst)
                     state <= st_single;
                  else if (need_hdr)
                     state <= st_wr_hdr;
                  else
                     state <= st_burst;
               end
            end
            st_wr_hdr: begin
               if (flit_acc) begin
                  hdr_idx <= !hdr_idx;
                  if (hdr_idx == 1'(header_flits - 1)) state <= st_burst;
               end
            end
            st_burst: begin
               if (flit_acc) begin
                  if (word_done) begin
                     flit_cnt <= '0;
                     need_hdr <= in_last;
                     state <= st_write;
                  end else begin
                     flit_cnt <= flit_cnt + 1'b1;
                     if (in_last) state <= st_wr_hdr;   // Word continues in next packet
                  end
               end
            end
            st_single: begin
               if (flit_acc) begin
                  if (word_done) begin
                     flit_cnt <= '0;
                     state <= st_write;
                  end else begin
                     flit_cnt <= flit_cnt + 1'b1;
                  end
               end
            end
            st_write: begin
               if (write_ready) begin
                  beats_left <= beats_left - 1'b1;
                  if (beats_left == beats_width'(1))
                     state <= req_sync ? st_sync_wait : st_hdr0;
                  else
                     state <= need_hdr ? st_wr_hdr : st_burst;
               end
            end
            st_sync_wait: if (write_complete) state <= st_hdr0;
            default: state <= st_hdr0;
         endcase
      end
   end

   // Request fields and write word
   always_ff @(posedge clk) begin
      if (state == st_cmd && flit_acc) begin
         req_rw <= cmd.burst_view.write;
         req_burst <= cmd.burst_view.burst;
         req_sync <= cmd.burst_view.sync;
         if (cmd.burst_view.burst) begin
            req_beats <= cmd.burst_view.beats;
            write_strb <= '1;
         end else begin
            req_beats <= beats_width'(1);
            write_strb <= (data_width/8)'(cmd.single_view.strb);
         end
      end
      if (state == st_addr && flit_acc)
         req_addr[flit_cnt*flit_width +: flit_width] <= in_data;   // LS flit first
      if ((state == st_burst || state == st_single) && flit_acc)
         word_buf[(word_flits-1-int'(flit_cnt))*flit_width +: flit_width] <= in_data;
   end

   // A posted request holds with its fields until taken
   req_hold: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid
         && $stable({req_rw, req_addr, req_burst, req_beats, req_sync}));

endmodule

// File: hdl/mam_resp_packetizer.sv
// Response packetizer: read data serializer, read response and sync acknowledge packets
module mam_resp_packetizer #(
   parameter int data_width = 32,
   parameter int max_pkt_len = 8,
   parameter bit big_endian = 1
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mam_pkg::flit_width-1:0]  id,
   input  logic                            read_start,
   input  logic [mam_pkg::beats_width-1:0] read_beats,
   input  logic                            sync_ack,
   output logic                            busy,
   input  logic                            read_valid,
   input  logic [data_width-1:0]           read_data,
   output logic                            read_ready,
   output logic [mam_pkg::flit_width-1:0]  out_data,
   output logic                            out_last,
   output logic                            out_valid,
   input  logic                            out_ready
);
   import mam_pkg::*;

   localparam int word_flits = flits_of(data_width);
   localparam int word_idx_width = cnt_bits(word_flits);
   localparam int pkt_cnt_width = cnt_bits(max_pkt_len);

   typedef enum logic [1:0] {
      st_idle,
      st_hdr,
      st_data
   } state_t;

   state_t state;
   logic ack_mode;                          // Header-only acknowledge packet
   logic [pkt_cnt_width-1:0] pkt_cnt;       // Flits sent in this packet, headers included
   logic [word_idx_width-1:0] word_idx;
   logic [beats_width-1:0] beats_left;
   logic [data_width-1:0] read_word;
   logic flit_acc;
   logic word_end;
   logic last_beat;
   logic pkt_full;

   assign read_word = big_endian ? read_data
                    : data_width'(swap_bytes(max_word_width'(read_data), data_width / 8));

   assign flit_acc = out_valid && out_ready;
   assign word_end = word_idx == word_idx_width'(word_flits - 1);
   assign last_beat = beats_left == beats_width'(1);
   assign pkt_full = pkt_cnt == pkt_cnt_width'(max_pkt_len - 1);
   assign busy = state != st_idle;
   assign read_ready = (state == st_data) && read_valid && out_ready && word_end;

   always_comb begin
      out_valid = 1'b0;
      out_data = hdr_dest_flit;
      out_last = 1'b0;
      case (state)
         st_hdr: begin
            out_valid = 1'b1;
            if (pkt_cnt == pkt_cnt_width'(header_flits - 1)) begin
               out_data = {hdr_type_bits, id[hdr_id_bits-1:0]};
               out_last = ack_mode;
            end
         end
         st_data: begin
            out_valid = read_valid;   // MS flit of the word goes first
            out_data = read_word[(word_flits-1-int'(word_idx))*flit_width +: flit_width];
            out_last = pkt_full || (word_end && last_beat);
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         ack_mode <= 1'b0;
         pkt_cnt <= '0;
         word_idx <= '0;
         beats_left <= '0;
      end else begin
         case (state)
            st_idle: begin
               pkt_cnt <= '0;
               word_idx <= '0;
               if (read_start) begin
                  ack_mode <= 1'b0;
                  beats_left <= read_beats;
                  state <= st_hdr;
               end else if (sync_ack) begin
                  ack_mode <= 1'b1;
                  state <= st_hdr;
               end
            end
            st_hdr: begin
               if (flit_acc) begin
                  pkt_cnt <= pkt_cnt + 1'b1;
                  if (pkt_cnt == pkt_cnt_width'(header_flits - 1))
                     state <= ack_mode ? st_idle : st_data;
               end
            end
            st_data: begin
               if (flit_acc) begin
                  word_idx <= word_end ? '0 : word_idx + 1'b1;
                  if (word_end) beats_left <= beats_left - 1'b1;
                  if (word_end && last_beat) begin
                     state <= st_idle;
                  end else if (pkt_full) begin
                     pkt_cnt <= '0;   // More beats left, open a new packet
                     state <= st_hdr;
                  end else begin
                     pkt_cnt <= pkt_cnt + 1'b1;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // An offered flit holds until taken
   out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: hdl/mam_top.sv
// Debug memory access unit top: command parser and response packetizer
module mam_top #(
   parameter int data_width = 32,    // Multiple of 16
   parameter int addr_width = 32,    // Multiple of 16
   parameter int max_pkt_len = 8,    // Flits per response packet, headers included
   parameter bit big_endian = 1      // 0 reverses bytes within a memory word
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mam_pkg::flit_width-1:0]  id,
   // Debug flits in
   input  logic [mam_pkg::flit_width-1:0]  in_data,
   input  logic                            in_last,
   input  logic                            in_valid,
   output logic                            in_ready,
   // Debug flits out
   output logic [mam_pkg::flit_width-1:0]  out_data,
   output logic                            out_last,
   output logic                            out_valid,
   input  logic                            out_ready,
   // Memory request
   output logic                            req_valid,
   input  logic                            req_ready,
   output logic                            req_rw,
   output logic [addr_width-1:0]           req_addr,
   output logic                            req_burst,
   output logic [mam_pkg::beats_width-1:0] req_beats,
   output logic                            req_sync,
   // Memory write
   output logic                            write_valid,
   output logic [data_width-1:0]           write_data,
   output logic [data_width/8-1:0]         write_strb,
   input  logic                            write_ready,
   input  logic                            write_complete,
   // Memory read
   input  logic                            read_valid,
   input  logic [data_width-1:0]           read_data,
   output logic                            read_ready
);
   import mam_pkg::*;

   logic read_start;
   logic [beats_width-1:0] read_beats;
   logic sync_ack;
   logic busy;

   mam_cmd_parser #(
      .data_width (data_width),
      .addr_width (addr_width),
      .big_endian (big_endian)
   ) u_parser (
      .clk, .rst,
      .in_data, .in_last, .in_valid, .in_ready,
      .req_valid, .req_ready, .req_rw, .req_addr, .req_burst, .req_beats, .req_sync,
      .write_valid, .write_data, .write_strb, .write_ready, .write_complete,
      .busy,
      .read_start, .read_beats,
      .sync_ack
   );

   mam_resp_packetizer #(
      .data_width  (data_width),
      .max_pkt_len (max_pkt_len),
      .big_endian  (big_endian)
   ) u_packetizer (
      .clk, .rst,
      .id,
      .read_start, .read_beats,
      .sync_ack,
      .busy,
      .read_valid, .read_data, .read_ready,
      .out_data, .out_last, .out_valid, .out_ready
   );

endmodule

// File: bench/mam_tests.svh
// Directed tests with flit send and receive helpers and counter waits
int out_rd = 0;               // Next flit of out_q to examine
logic [15:0] rx_data[$];      // Data flits of the current read response

function automatic int progress(input int which);
   case (which)
      cnt_writes: return wr_data_q.size();
      cnt_out_flits: return out_q.size();
      default: return cpl_count;
   endcase
endfunction

task automatic wait_count(input string what, input int which, input int target);
   int t;
   t = 0;
   while (progress(which) < target) begin
      @(negedge clk);
      t++;
      if (t > timeout_cycles) timed_out(what);
   end
endtask

task automatic send_flit(input logic [15:0] data, input logic last);
   int t;
   bit taken;
   t = 0;
   taken = 1'b0;
   if (gaps)
      repeat ($urandom_range(0, 2)) @(negedge clk);   // Idle gap, in_valid low
   in_data = data;
   in_last = last;
   in_valid = 1'b1;
   while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      t++;
      if (t > timeout_cycles) timed_out("inbound flit acceptance");
   end
   @(negedge clk);
   in_valid = 1'b0;
endtask

task automatic send_header();
   send_flit(dut_id, 1'b0);
   send_flit(16'h4000, 1'b0);
endtask

task automatic send_cmd_addr(input logic [15:0] cmd, input logic [31:0] addr, input bit last);
   send_header();
   send_flit(cmd, 1'b0);
   send_flit(addr[15:0], 1'b0);     // LS flit first
   send_flit(addr[31:16], last);
endtask

// One response packet, data flits are appended to rx_data
task automatic recv_packet(input string name, output int len);
   logic [15:0] flit;
   logic last;
   len = 0;
   last = 1'b0;
   while (!last) begin
      wait_count({name, " response flit"}, cnt_out_flits, out_rd + 1);
      flit = out_q[out_rd];
      last = out_last_q[out_rd];
      out_rd++;
      len++;
      if (len == 1)
         check({name, " dest flit"}, 32'h0, 32'(flit));
      else if (len == 2)
         check({name, " type and id flit"}, 32'({6'b011111, dut_id[9:0]}), 32'(flit));
      else
         rx_data.push_back(flit);
      if (len > max_pkt_len) begin
         $display("%s: response packet runs past %0d flits without out_last", name, len - 1);
         stop_failed();
      end
   end
endtask

task automatic single_write();
   int base;
   base = wr_data_q.size();
   send_cmd_addr(16'h8006, 32'h1000_0040, 1'b0);   // Write, no burst, strobe 0110
   send_flit(16'h1122, 1'b0);
   send_flit(16'h3344, 1'b1);
   wait_count("single write word", cnt_writes, base + 1);
   check("single req_rw", 32'd1, 32'(last_rw));
   check("single req_burst", 32'd0, 32'(last_burst));
   check("single req_beats", 32'd1, 32'(last_beats));
   check("single req_addr", 32'h1000_0040, last_addr);
   check("single write_strb", 32'h6, 32'(wr_strb_q[base]));
   check("single write_data", 32'h4433_2211, wr_data_q[base]);
endtask

// Data flits before index split go in the command packet, the rest in a second one
task automatic burst_write(input string name, input logic [31:0] addr, input int nbeats,
                           input bit sync, input int split);
   logic [31:0] words[$];
   logic [15:0] flit;
   int base;
   int out_base;
   base = wr_data_q.size();
   out_base = out_q.size();
   for (int k = 0; k < nbeats; k++)
      words.push_back(gaps ? $urandom : {16'hc0de, 8'(k), 8'h5a});
   send_cmd_addr({1'b1, 1'b1, sync, 13'(nbeats)}, addr, split == 0);
   for (int i = 0; i < 2 * nbeats; i++) begin
      if (i == split) send_header();
      flit = (i % 2 == 1) ? words[i/2][15:0] : words[i/2][31:16];
      send_flit(flit, i == split - 1 || i == 2 * nbeats - 1);
   end
   wait_count({name, " write words"}, cnt_writes, base + nbeats);
   check({name, " req_rw"}, 32'd1, 32'(last_rw));
   check({name, " req_burst"}, 32'd1, 32'(last_burst));
   check({name, " req_beats"}, 32'(nbeats), 32'(last_beats));
   check({name, " req_sync"}, 32'(sync), 32'(last_sync));
   for (int k = 0; k < nbeats; k++) begin
      check({name, " word"}, byte_rev(words[k]), wr_data_q[base + k]);
      check({name, " word strobe"}, 32'hf, 32'(wr_strb_q[base + k]));
      check({name, " word address"}, addr + 32'(4 * k), wr_addr_q[base + k]);
   end
   if (!sync) begin
      repeat (8) @(negedge clk);    // Room for a stray response
      check({name, " response flits"}, 32'(out_base), 32'(out_q.size()));
   end
endtask

task automatic burst_read(input string name, input logic [31:0] addr, input int nbeats);
   int len;
   logic [31:0] exp_word;
   rx_data.delete();
   send_cmd_addr({3'b010, 13'(nbeats)}, addr, 1'b1);
   while (rx_data.size() < 2 * nbeats) begin
      recv_packet(name, len);
      check({name, " packet carries data"}, 32'd1, 32'(len > 2));
   end
   check({name, " req_rw"}, 32'd0, 32'(last_rw));
   check({name, " req_beats"}, 32'(nbeats), 32'(last_beats));
   check({name, " req_addr"}, addr, last_addr);
   check({name, " data flit count"}, 32'(2 * nbeats), 32'(rx_data.size()));
   for (int k = 0; k < nbeats; k++) begin
      exp_word = byte_rev(word_at(addr + 32'(4 * k)));
      check({name, " data word"}, exp_word, {rx_data[2*k], rx_data[2*k+1]});
   end
endtask

task automatic sync_write();
   int cpl_base;
   int out_base;
   int len;
   cpl_base = cpl_count;
   out_base = out_q.size();
   burst_write("sync write", 32'h0000_4000, 2, 1'b1, 4);
   wait_count("write_complete", cnt_acks, cpl_base + 1);
   check("sync flits before write_complete", 32'(out_base), 32'(out_q.size()));
   recv_packet("sync ack", len);
   check("sync ack length", 32'd2, 32'(len));
   repeat (8) @(negedge clk);
   check("sync ack packet count", 32'(out_rd), 32'(out_q.size()));
endtask

// File: bench/mam_tb.sv
// Testbench top: clock, reset, DUT, memory model, check task and test sequence
module mam_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [15:0] dut_id = 16'h0005;
   localparam int max_pkt_len = 6;
   localparam int timeout_cycles = 400;
   localparam int cnt_writes = 0;       // Counters a wait can watch
   localparam int cnt_out_flits = 1;
   localparam int cnt_acks = 2;

   logic clk = 1'b0;
   logic rst;
   logic [15:0] in_data, out_data;
   logic in_last, in_valid, in_ready, out_last, out_valid;
   logic req_valid, req_rw, req_burst, req_sync, write_valid, read_ready;
   logic [31:0] req_addr, write_data;
   logic [12:0] req_beats;
   logic [3:0] write_strb;
   logic out_ready = 1'b0;
   logic req_ready = 1'b0;
   logic write_ready = 1'b0;
   logic write_complete = 1'b0;
   logic read_valid = 1'b0;
   logic [31:0] read_data = '0;

   // Memory model state
   logic [31:0] mem [logic [31:0]];
   logic [31:0] mem_addr = '0;          // Next word of the open access
   logic [31:0] last_addr;
   logic [12:0] last_beats;
   logic last_rw, last_burst, last_sync;
   logic sync_pending = 1'b0;           // Last sync write taken, completion still due
   int wr_left = 0;
   int rd_left = 0;
   int rd_done = 0;
   int rd_seen = 0;
   int cpl_count = 0;
   int cpl_delay = 0;
   bit gaps = 1'b0;                     // Random stalls on every handshake
   logic [31:0] wr_data_q[$], wr_addr_q[$];
   logic [3:0] wr_strb_q[$];
   logic [15:0] out_q[$];               // Every accepted outbound flit
   logic out_last_q[$];

   always #20 clk = ~clk;

   mam_top #(
      .data_width  (32),
      .addr_width  (32),
      .max_pkt_len (max_pkt_len),
      .big_endian  (1'b0)
   ) u_dut (
      .id (dut_id),
      .*
   );

   function automatic logic [31:0] byte_rev(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // Untouched words read back a pattern built from their address
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
   endfunction

   function automatic logic [31:0] word_at(input logic [31:0] a);
      return mem.exists(a) ? mem[a] : fill_word(a);
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, new_w,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old_w;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
      end
      return res;
   endfunction

   task automatic stop_failed();
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic timed_out(input string what);
      $display("timeout: %s did not happen within %0d cycles", what, timeout_cycles);
      stop_failed();
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         stop_failed();
      end
   endtask

   // Memory side: record requests, writes, reads and outbound flits
   always @(posedge clk) begin
      if (req_valid && req_ready) begin
         last_rw = req_rw;
         last_burst = req_burst;
         last_sync = req_sync;
         last_beats = req_beats;
         last_addr = req_addr;
         mem_addr = req_addr;
         if (req_rw) wr_left = int'(req_beats);
         else rd_left = int'(req_beats);
      end
      if (write_valid && write_ready) begin
         wr_data_q.push_back(write_data);
         wr_strb_q.push_back(write_strb);
         wr_addr_q.push_back(mem_addr);
         mem[mem_addr] = merge_bytes(word_at(mem_addr), write_data, write_strb);
         mem_addr = mem_addr + 32'd4;
         wr_left--;
         if (wr_left == 0 && last_sync) sync_pending = 1'b1;
      end
      if (read_valid && read_ready) begin
         mem_addr = mem_addr + 32'd4;
         rd_left--;
         rd_done++;
      end
      if (write_complete && sync_pending) begin
         sync_pending = 1'b0;
         cpl_count++;
      end
      if (out_valid && out_ready) begin
         out_q.push_back(out_data);
         out_last_q.push_back(out_last);
      end
   end

   // Memory side outputs change on the falling edge
   always @(negedge clk) begin
      req_ready = !gaps || $urandom_range(0, 2) != 0;
      write_ready = !gaps || $urandom_range(0, 2) != 0;
      out_ready = !gaps || $urandom_range(0, 2) != 0;
      if (rd_left > 0) begin
         if (!read_valid || rd_done != rd_seen) begin   // An offered word holds until taken
            read_valid = !gaps || $urandom_range(0, 2) != 0;
            read_data = word_at(mem_addr);
         end
      end else begin
         read_valid = 1'b0;
      end
      rd_seen = rd_done;
      if (sync_pending) begin
         cpl_delay++;
         if (cpl_delay == 3) write_complete = 1'b1;
      end else begin
         cpl_delay = 0;
         write_complete = 1'b0;
      end
   end

   `include "mam_tests.svh"

   initial begin
      void'($urandom(22));
      rst = 1'b1;
      in_data = '0;
      in_last = 1'b0;
      in_valid = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check("in_ready after reset", 32'd1, 32'(in_ready));
      check("req_valid after reset", 32'd0, 32'(req_valid));
      check("write_valid after reset", 32'd0, 32'(write_valid));
      check("read_ready after reset", 32'd0, 32'(read_ready));
      check("out_valid after reset", 32'd0, 32'(out_valid));
      single_write();
      burst_write("burst write", 32'h0000_2000, 5, 1'b0, 5);   // Split inside word 2
      burst_read("burst read", 32'h0000_2000, 7);
      sync_write();
      gaps = 1'b1;
      burst_write("stalled burst write", 32'h0000_3000, 5, 1'b0, 0);
      burst_read("stalled burst read", 32'h0000_3000, 7);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// File: sim.f
+incdir+bench
hdl/mam_pkg.sv
hdl/mam_cmd_parser.sv
hdl/mam_resp_packetizer.sv
hdl/mam_top.sv
bench/mam_tb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run; $fatal in the testbench gives a non-zero exit
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module mam_tb -f sim.f -Mdir obj_dir
./obj_dir/Vmam_tb
